// ==== cpu.f ====
+incdir+common
common/CpuPackage.sv
verilog/Alu.sv
verilog/InstructionDecoder.sv
verilog/RegisterFile.sv
verilog/BranchUnit.sv
memory/UnifiedMemory.sv
memory/MemoryRouter.sv
verilog/CpuTop.sv
tests/CpuTop_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CpuTop testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module CpuTop_tb -f cpu.f \
	--Mdir obj_dir -o CpuTop_sim > build.log 2>&1
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

./obj_dir/CpuTop_sim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
fi

if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tests/CpuTop_tb.sv ====
`default_nettype none
`include "cpu_consts.svh"

module CpuTop_tb;
	import CpuPackage::*;

	logic clk;
	logic rst;
	logic externalMemoryControl;
	word_t externalAddress;
	word_t externalData;
	memOp_t externalMemOp;
	word_t externalDataOut;
	word_t sevenSegmentDisplayOutput;

	logic [31:0] lfsrState;
	word_t codeWords [$];

	CpuTop UUT (
		.clk(clk),
		.rst(rst),
		.externalMemoryControl(externalMemoryControl),
		.externalAddress(externalAddress),
		.externalData(externalData),
		.externalMemOp(externalMemOp),
		.externalDataOut(externalDataOut),
		.sevenSegmentDisplayOutput(sevenSegmentDisplayOutput)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] nextLfsr(logic [31:0] state);
		return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
	endfunction

	task automatic drawBits(input int count, output word_t value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = nextLfsr(lfsrState);
		end
	endtask

	task automatic failRun();
		$display("TEST FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic compareWord(string testName, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %h, actual %h", testName, expected, actual);
			failRun();
		end
	endtask

	// Instruction encoders
	function automatic word_t rType(logic [5:0] funct, regAddr_t rs, regAddr_t rt,
		regAddr_t rd, shamt_t shamt);
		return {`OP_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t iType(logic [5:0] opcode, regAddr_t rs, regAddr_t rt,
		logic [15:0] immediate);
		return {opcode, rs, rt, immediate};
	endfunction

	function automatic word_t jType(logic [5:0] opcode, word_t target);
		return {opcode, target[27:2]};
	endfunction

	// Offset counts words from the slot right after the branch
	function automatic logic [15:0] offsetTo(int branchIndex, int targetIndex);
		return 16'(targetIndex - branchIndex - 1);
	endfunction

	function automatic word_t signExtend16(logic [15:0] value);
		return {{16{value[15]}}, value};
	endfunction

	task automatic emit(word_t instruction);
		codeWords.push_back(instruction);
	endtask

	task automatic holdReset();
		@(posedge clk);
		rst <= 1'b0;
		repeat (10) @(posedge clk);
	endtask

	task automatic releaseReset();
		@(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic writeExternal(word_t address, word_t data);
		@(posedge clk);
		externalMemoryControl <= 1'b1;
		externalAddress <= address;
		externalData <= data;
		externalMemOp <= memWrite;
	endtask

	// Data shows one cycle after the request
	task automatic readExternal(input word_t address, output word_t data);
		@(posedge clk);
		externalMemoryControl <= 1'b1;
		externalAddress <= address;
		externalMemOp <= memRead;
		@(posedge clk);
		externalMemOp <= memNone;
		@(negedge clk);
		data = externalDataOut;
	endtask

	task automatic releaseBus();
		@(posedge clk);
		externalMemoryControl <= 1'b0;
		externalMemOp <= memNone;
	endtask

	// Appends a jump-to-self with its two nop slots, then writes the code at the reset vector
	task automatic loadProgram();
		word_t haltAddress;
		haltAddress = `RESET_VECTOR + word_t'(4 * codeWords.size());
		emit(jType(`OP_J, haltAddress));
		emit(32'd0);
		emit(32'd0);
		for (int i = 0; i < codeWords.size(); i++)
			writeExternal(`RESET_VECTOR + word_t'(4 * i), codeWords[i]);
		releaseBus();
		codeWords.delete();
	endtask

	// The first display change must already be the expected value
	task automatic waitForDisplay(string testName, word_t expected);
		int cycles;
		word_t startValue;
		cycles = 0;
		@(negedge clk);
		startValue = sevenSegmentDisplayOutput;
		while (sevenSegmentDisplayOutput === startValue && cycles < 300) begin
			@(negedge clk);
			cycles++;
		end
		if (sevenSegmentDisplayOutput === startValue && startValue !== expected) begin
			$display("Timed out in %s waiting for the display to change", testName);
			failRun();
		end
		compareWord(testName, expected, sevenSegmentDisplayOutput);
	endtask

	task automatic checkResetState();
		holdReset();
		loadProgram();
		compareWord("reset display in reset", 32'd0, sevenSegmentDisplayOutput);
		releaseReset();
		@(negedge clk);
		compareWord("reset display", 32'd0, sevenSegmentDisplayOutput);
		compareWord("reset external data", 32'd0, externalDataOut);
	endtask

	task automatic checkExternalAccess();
		word_t addresses [8];
		word_t words [8];
		word_t readBack;
		word_t aliasOffset;
		holdReset();
		loadProgram();
		releaseReset();
		for (int i = 0; i < 8; i++) begin
			drawBits(32, words[i]);
			addresses[i] = 32'd2048 + word_t'(i * 68);
			writeExternal(addresses[i], words[i]);
		end
		// RAM words that alias the peripheral addresses must not show through
		aliasOffset = word_t'(4 * `MEM_WORDS);
		writeExternal(`DISPLAY_ADDRESS + aliasOffset, 32'hffff_ffff);
		writeExternal(32'd512 + aliasOffset, 32'hffff_ffff);
		for (int i = 0; i < 8; i++) begin
			readExternal(addresses[i], readBack);
			compareWord("external read", words[i], readBack);
		end
		readExternal(`DISPLAY_ADDRESS, readBack);
		compareWord("external peripheral read", 32'd0, readBack);
		readExternal(32'd512, readBack);
		compareWord("external low read", 32'd0, readBack);
		// Handing the bus back hides the pending read data
		@(posedge clk);
		externalAddress <= addresses[0];
		externalMemOp <= memRead;
		@(posedge clk);
		externalMemoryControl <= 1'b0;
		externalMemOp <= memNone;
		@(negedge clk);
		compareWord("external data after release", 32'd0, externalDataOut);
	endtask

	task automatic checkArithmetic();
		word_t draw;
		logic [15:0] immediates [4];
		shamt_t shiftAmount;
		word_t model [11];
		for (int i = 0; i < 4; i++) begin
			drawBits(16, draw);
			immediates[i] = draw[15:0];
		end
		drawBits(5, draw);
		shiftAmount = draw[4:0];
		holdReset();
		emit(iType(`OP_ADDI, 5'd0, 5'd1, immediates[0]));
		emit(iType(`OP_ORI, 5'd1, 5'd2, immediates[1]));
		emit(iType(`OP_XORI, 5'd2, 5'd3, immediates[2]));
		emit(rType(`FN_SUB, 5'd3, 5'd1, 5'd4, 5'd0));
		emit(rType(`FN_SLL, 5'd0, 5'd4, 5'd5, shiftAmount));
		emit(rType(`FN_SRA, 5'd0, 5'd5, 5'd6, 5'd3));
		emit(rType(`FN_ADD, 5'd6, 5'd2, 5'd7, 5'd0));
		emit(rType(`FN_NOR, 5'd7, 5'd1, 5'd8, 5'd0));
		emit(iType(`OP_SLTI, 5'd8, 5'd9, immediates[3]));
		emit(rType(`FN_OR, 5'd8, 5'd9, 5'd10, 5'd0));
		emit(iType(`OP_SW, 5'd0, 5'd10, 16'd256));
		loadProgram();
		releaseReset();
		// Register model, indexed by register number
		model[0] = 32'd0;
		model[1] = signExtend16(immediates[0]);
		model[2] = model[1] | {16'd0, immediates[1]};
		model[3] = model[2] ^ {16'd0, immediates[2]};
		model[4] = model[3] - model[1];
		model[5] = model[4] << shiftAmount;
		model[6] = word_t'($signed(model[5]) >>> 3);
		model[7] = model[6] + model[2];
		model[8] = ~(model[7] | model[1]);
		model[9] = {31'd0, $signed(model[8]) < $signed(signExtend16(immediates[3]))};
		model[10] = model[8] | model[9];
		waitForDisplay("arithmetic chain", model[10]);
	endtask

	task automatic checkLoadStore();
		word_t storedWord;
		word_t draw;
		logic [15:0] addend;
		word_t readBack;
		drawBits(32, storedWord);
		drawBits(16, draw);
		addend = draw[15:0];
		holdReset();
		emit(iType(`OP_ADDI, 5'd0, 5'd1, 16'h0c00));
		emit(iType(`OP_ORI, 5'd0, 5'd2, storedWord[31:16]));
		emit(rType(`FN_SLL, 5'd0, 5'd2, 5'd2, 5'd16));
		emit(iType(`OP_ORI, 5'd2, 5'd2, storedWord[15:0]));
		emit(iType(`OP_SW, 5'd1, 5'd2, 16'd8));
		emit(iType(`OP_ADDI, 5'd0, 5'd3, addend));
		emit(iType(`OP_LW, 5'd1, 5'd4, 16'd8));
		// Unrelated filler between the load and its use
		emit(iType(`OP_ADDI, 5'd0, 5'd5, 16'd1));
		emit(rType(`FN_ADD, 5'd4, 5'd3, 5'd6, 5'd0));
		emit(iType(`OP_SW, 5'd0, 5'd6, 16'd256));
		loadProgram();
		releaseReset();
		waitForDisplay("load and add", storedWord + signExtend16(addend));
		readExternal(32'd3080, readBack);
		compareWord("stored word", storedWord, readBack);
		releaseBus();
	endtask

	task automatic checkBranches();
		word_t jalAddress;
		word_t readBack;
		jalAddress = `RESET_VECTOR + word_t'(4 * 13);
		holdReset();
		writeExternal(32'd3072, 32'd0);
		emit(iType(`OP_ADDI, 5'd0, 5'd20, 16'h0c00));
		emit(iType(`OP_ADDI, 5'd0, 5'd1, 16'd5));
		emit(iType(`OP_ADDI, 5'd0, 5'd2, 16'd5));
		emit(iType(`OP_ADDI, 5'd0, 5'd3, 16'h0bad));
		emit(iType(`OP_BEQ, 5'd1, 5'd2, offsetTo(4, 9)));
		emit(iType(`OP_ORI, 5'd0, 5'd10, 16'h0001));
		emit(iType(`OP_ORI, 5'd10, 5'd10, 16'h0002));
		emit(iType(`OP_SW, 5'd0, 5'd3, 16'd256));
		emit(iType(`OP_ORI, 5'd10, 5'd10, 16'h0080));
		// Taken by mistake, it lands on the marker store
		emit(iType(`OP_BNE, 5'd1, 5'd2, offsetTo(9, 7)));
		emit(iType(`OP_ORI, 5'd10, 5'd10, 16'h0004));
		emit(iType(`OP_ORI, 5'd10, 5'd10, 16'h0008));
		emit(iType(`OP_ORI, 5'd10, 5'd10, 16'h0010));
		emit(jType(`OP_JAL, `RESET_VECTOR + word_t'(4 * 17)));
		emit(iType(`OP_ORI, 5'd10, 5'd10, 16'h0020));
		emit(iType(`OP_ORI, 5'd10, 5'd10, 16'h0040));
		emit(iType(`OP_SW, 5'd0, 5'd3, 16'd256));
		emit(iType(`OP_SW, 5'd20, 5'd10, 16'd0));
		emit(iType(`OP_SW, 5'd0, `LINK_REG, 16'd256));
		loadProgram();
		releaseReset();
		waitForDisplay("jal link address", jalAddress + 32'd12);
		// One bit per delay slot and fall-through, none from skipped code
		readExternal(32'd3072, readBack);
		compareWord("executed slots", 32'h0000_007f, readBack);
		releaseBus();
	endtask

	initial begin
		repeat (5000) @(posedge clk);
		$display("Watchdog expired before all tests finished");
		failRun();
	end

	initial begin
		lfsrState = 32'hd355_35b5;
		rst <= 1'b0;
		externalMemoryControl <= 1'b0;
		externalAddress <= '0;
		externalData <= '0;
		externalMemOp <= memNone;
		checkResetState();
		checkExternalAccess();
		checkArithmetic();
		checkLoadStore();
		checkBranches();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/CpuTop.sv ====
`default_nettype none

module CpuTop (
	input logic clk,
	input logic rst,
	input logic externalMemoryControl,
	input CpuPackage::word_t externalAddress,
	input CpuPackage::word_t externalData,
	input CpuPackage::memOp_t externalMemOp,
	output CpuPackage::word_t externalDataOut,
	output CpuPackage::word_t sevenSegmentDisplayOutput
);
	import CpuPackage::*;

	// Fetch stage
	word_t pcAddress;
	word_t instruction;
	word_t fetchPc;
	logic fetchValid;

	// Decoder outputs
	regAddr_t decRs;
	regAddr_t decRt;
	regAddr_t decDest;
	word_t decImmediate;
	logic [25:0] decJumpTarget;
	shamt_t decShamt;
	aluOp_t decAluOp;
	logic decUseImmediate;
	logic decRegisterWrite;
	writeSource_t decWriteSource;
	memOp_t decMemOp;
	branchMode_t decBranchMode;
	word_t rsValue;
	word_t rtValue;

	// Decode register, read by execute
	word_t exPc;
	regAddr_t exRs;
	regAddr_t exRt;
	regAddr_t exDest;
	word_t exImmediate;
	logic [25:0] exJumpTarget;
	shamt_t exShamt;
	aluOp_t exAluOp;
	logic exUseImmediate;
	logic exRegisterWrite;
	writeSource_t exWriteSource;
	memOp_t exMemOp;
	branchMode_t exBranchMode;
	word_t exRsValue;
	word_t exRtValue;

	// Execute stage
	word_t rsOperand;
	word_t rtOperand;
	word_t aluOperandB;
	word_t aluResult;
	logic isZero;
	logic isPositive;
	logic isNegative;

	// Memory data path
	word_t memAddress;
	word_t memWriteData;
	memOp_t memOp;
	word_t memReadData;
	word_t cpuReadData;

	// Writeback register
	logic wbRegisterWrite;
	regAddr_t wbDest;
	writeSource_t wbWriteSource;
	word_t wbAluResult;
	word_t wbLinkAddress;
	word_t wbData;

	BranchUnit branchUnit (
		.clk(clk),
		.rst(rst),
		.branchMode(exBranchMode),
		.branchPc(exPc),
		.offset(exImmediate),
		.jumpTarget(exJumpTarget),
		.jumpRegister(rsOperand),
		.isZero(isZero),
		.isPositive(isPositive),
		.isNegative(isNegative),
		.pcAddress(pcAddress)
	);

	UnifiedMemory memory (
		.clk(clk),
		.fetchAddress(pcAddress),
		.fetchData(instruction),
		.dataAddress(memAddress),
		.dataOp(memOp),
		.writeData(memWriteData),
		.readData(memReadData)
	);

	InstructionDecoder decoder (
		.instruction(instruction),
		.rsAddress(decRs),
		.rtAddress(decRt),
		.destAddress(decDest),
		.immediate(decImmediate),
		.jumpTarget(decJumpTarget),
		.shamt(decShamt),
		.aluOp(decAluOp),
		.useImmediate(decUseImmediate),
		.registerWrite(decRegisterWrite),
		.writeSource(decWriteSource),
		.memOp(decMemOp),
		.branchMode(decBranchMode)
	);

	RegisterFile registerFile (
		.clk(clk),
		.rst(rst),
		.rsAddress(decRs),
		.rtAddress(decRt),
		.writeAddress(wbDest),
		.registerWrite(wbRegisterWrite),
		.writeData(wbData),
		.rsValue(rsValue),
		.rtValue(rtValue)
	);

	// PC of the instruction now leaving the memory
	always_ff @(posedge clk) begin
		fetchPc <= pcAddress;
	end

	// The first word after reset was fetched while reset was held
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fetchValid <= 1'b0;
			exRegisterWrite <= 1'b0;
			exWriteSource <= writeNone;
			exMemOp <= memNone;
			exBranchMode <= branchNone;
		end else begin
			fetchValid <= 1'b1;
			exRegisterWrite <= decRegisterWrite && fetchValid;
			exWriteSource <= fetchValid ? decWriteSource : writeNone;
			exMemOp <= fetchValid ? decMemOp : memNone;
			exBranchMode <= fetchValid ? decBranchMode : branchNone;
		end
	end

	always_ff @(posedge clk) begin
		exPc <= fetchPc;
		exRs <= decRs;
		exRt <= decRt;
		exDest <= decDest;
		exImmediate <= decImmediate;
		exJumpTarget <= decJumpTarget;
		exShamt <= decShamt;
		exAluOp <= decAluOp;
		exUseImmediate <= decUseImmediate;
		exRsValue <= rsValue;
		exRtValue <= rtValue;
	end

	// Only an ALU result from the instruction just ahead is forwarded
	function automatic word_t forward(regAddr_t source, word_t registerValue);
		if (wbRegisterWrite && wbWriteSource == writeAluResult
			&& source != '0 && source == wbDest)
			return wbAluResult;
		return registerValue;
	endfunction

	always_comb begin
		rsOperand = forward(exRs, exRsValue);
		rtOperand = forward(exRt, exRtValue);
		aluOperandB = exUseImmediate ? exImmediate : rtOperand;
	end

	Alu alu (
		.operandA(rsOperand),
		.operandB(aluOperandB),
		.shamt(exShamt),
		.aluOp(exAluOp),
		.result(aluResult),
		.isZero(isZero),
		.isPositive(isPositive),
		.isNegative(isNegative)
	);

	MemoryRouter memoryRouter (
		.clk(clk),
		.rst(rst),
		.externalMemoryControl(externalMemoryControl),
		.externalAddress(externalAddress),
		.externalData(externalData),
		.externalMemOp(externalMemOp),
		.externalDataOut(externalDataOut),
		.cpuAddress(aluResult),
		.cpuWriteData(rtOperand),
		.cpuMemOp(exMemOp),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.memOp(memOp),
		.memReadData(memReadData),
		.cpuReadData(cpuReadData),
		.displayValue(sevenSegmentDisplayOutput)
	);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wbRegisterWrite <= 1'b0;
			wbWriteSource <= writeNone;
		end else begin
			wbRegisterWrite <= exRegisterWrite;
			wbWriteSource <= exWriteSource;
		end
	end

	// Link skips the jump and both delay slots
	always_ff @(posedge clk) begin
		wbDest <= exDest;
		wbAluResult <= aluResult;
		wbLinkAddress <= exPc + 32'd12;
	end

	always_comb begin
		case (wbWriteSource)
			writeAluResult: wbData = wbAluResult;
			writeMemData: wbData = cpuReadData;
			writeLinkAddress: wbData = wbLinkAddress;
			default: wbData = '0;
		endcase
	end

	// Load data arrives in writeback, too late for the next instruction
	assert property (@(posedge clk) disable iff (!rst)
		(wbRegisterWrite && wbWriteSource == writeMemData && wbDest != '0)
		|-> (exRs != wbDest && exRt != wbDest))
		else $error("Load destination read by the next instruction");

endmodule

`default_nettype wire

// ==== memory/MemoryRouter.sv ====
`default_nettype none
`include "cpu_consts.svh"

module MemoryRouter (
	input logic clk,
	input logic rst,
	input logic externalMemoryControl,
	input CpuPackage::word_t externalAddress,
	input CpuPackage::word_t externalData,
	input CpuPackage::memOp_t externalMemOp,
	output CpuPackage::word_t externalDataOut,
	input CpuPackage::word_t cpuAddress,
	input CpuPackage::word_t cpuWriteData,
	input CpuPackage::memOp_t cpuMemOp,
	output CpuPackage::word_t memAddress,
	output CpuPackage::word_t memWriteData,
	output CpuPackage::memOp_t memOp,
	input CpuPackage::word_t memReadData,
	output CpuPackage::word_t cpuReadData,
	output CpuPackage::word_t displayValue
);
	import CpuPackage::*;

	word_t busAddress;
	word_t busWriteData;
	memOp_t busOp;
	logic inRam;
	logic readWasRam;
	word_t routedReadData;

	// External bus takes over and the CPU request is dropped
	assign busAddress = externalMemoryControl ? externalAddress : cpuAddress;
	assign busWriteData = externalMemoryControl ? externalData : cpuWriteData;
	assign busOp = externalMemoryControl ? externalMemOp : cpuMemOp;

	assign inRam = busAddress >= `DATA_BASE;
	assign memAddress = busAddress;
	assign memWriteData = busWriteData;
	assign memOp = inRam ? busOp : memNone;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			readWasRam <= 1'b0;
			displayValue <= '0;
		end else begin
			// RAM data comes back a cycle later
			readWasRam <= inRam && busOp == memRead;
			if (busOp == memWrite && busAddress == `DISPLAY_ADDRESS)
				displayValue <= busWriteData;
		end
	end

	// Peripheral reads return zero
	assign routedReadData = readWasRam ? memReadData : '0;
	assign cpuReadData = routedReadData;
	assign externalDataOut = externalMemoryControl ? routedReadData : '0;

endmodule

`default_nettype wire

// ==== memory/UnifiedMemory.sv ====
`default_nettype none
`include "cpu_consts.svh"

module UnifiedMemory #(
	parameter int WORDS = `MEM_WORDS
) (
	input logic clk,
	input CpuPackage::word_t fetchAddress,
	output CpuPackage::word_t fetchData,
	input CpuPackage::word_t dataAddress,
	input CpuPackage::memOp_t dataOp,
	input CpuPackage::word_t writeData,
	output CpuPackage::word_t readData
);
	import CpuPackage::*;

	localparam int indexWidth = $clog2(WORDS);

	word_t storage [WORDS];
	logic [indexWidth-1:0] fetchIndex;
	logic [indexWidth-1:0] dataIndex;

	// Upper address bits are dropped, so addresses wrap around the array
	assign fetchIndex = fetchAddress[indexWidth+1:2];
	assign dataIndex = dataAddress[indexWidth+1:2];

	always_ff @(posedge clk) begin
		fetchData <= storage[fetchIndex];
	end

	// Read during write returns the old word
	always_ff @(posedge clk) begin
		if (dataOp == memWrite)
			storage[dataIndex] <= writeData;
		readData <= storage[dataIndex];
	end

	assert property (@(posedge clk) dataOp != memNone |-> dataAddress[1:0] == 2'b00)
		else $error("Unaligned data access at %h", dataAddress);

endmodule

`default_nettype wire

// ==== verilog/BranchUnit.sv ====
`default_nettype none
`include "cpu_consts.svh"

module BranchUnit (
	input logic clk,
	input logic rst,
	input CpuPackage::branchMode_t branchMode,
	input CpuPackage::word_t branchPc,
	input CpuPackage::word_t offset,
	input logic [25:0] jumpTarget,
	input CpuPackage::word_t jumpRegister,
	input logic isZero,
	input logic isPositive,
	input logic isNegative,
	output CpuPackage::word_t pcAddress
);
	import CpuPackage::*;

	word_t sequentialPc;
	word_t branchTarget;
	word_t jumpAddress;
	word_t nextPc;
	logic taken;

	assign sequentialPc = branchPc + 32'd4;
	assign branchTarget = sequentialPc + {offset[29:0], 2'b00};
	assign jumpAddress = {sequentialPc[31:28], jumpTarget, 2'b00};

	always_comb begin
		case (branchMode)
			branchEq: taken = isZero;
			branchNe: taken = !isZero;
			branchLez: taken = isZero || isNegative;
			branchGtz: taken = isPositive;
			branchJump: taken = 1'b1;
			branchJumpReg: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// Fetch runs two words ahead of execute, which gives the two delay slots
	always_comb begin
		if (!taken)
			nextPc = pcAddress + 32'd4;
		else if (branchMode == branchJump)
			nextPc = jumpAddress;
		else if (branchMode == branchJumpReg)
			nextPc = jumpRegister;
		else
			nextPc = branchTarget;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			pcAddress <= `RESET_VECTOR;
		else
			pcAddress <= nextPc;
	end

	assert property (@(posedge clk) disable iff (!rst) pcAddress[1:0] == 2'b00)
		else $error("PC %h is not word-aligned", pcAddress);

endmodule

`default_nettype wire

// ==== verilog/RegisterFile.sv ====
`default_nettype none

module RegisterFile (
	input logic clk,
	input logic rst,
	input CpuPackage::regAddr_t rsAddress,
	input CpuPackage::regAddr_t rtAddress,
	input CpuPackage::regAddr_t writeAddress,
	input logic registerWrite,
	input CpuPackage::word_t writeData,
	output CpuPackage::word_t rsValue,
	output CpuPackage::word_t rtValue
);
	import CpuPackage::*;

	word_t registers [32];

	// Register zero is never written and stays at zero
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				registers[i] <= '0;
			end
		end else if (registerWrite && writeAddress != '0) begin
			registers[writeAddress] <= writeData;
		end
	end

	// Write-through so writeback and decode can share a cycle
	function automatic word_t readPort(regAddr_t address);
		if (registerWrite && address != '0 && address == writeAddress)
			return writeData;
		return registers[address];
	endfunction

	always_comb begin
		rsValue = readPort(rsAddress);
		rtValue = readPort(rtAddress);
	end

endmodule

`default_nettype wire

// ==== verilog/InstructionDecoder.sv ====
`default_nettype none
`include "cpu_consts.svh"

module InstructionDecoder (
	input CpuPackage::word_t instruction,
	output CpuPackage::regAddr_t rsAddress,
	output CpuPackage::regAddr_t rtAddress,
	output CpuPackage::regAddr_t destAddress,
	output CpuPackage::word_t immediate,
	output logic [25:0] jumpTarget,
	output CpuPackage::shamt_t shamt,
	output CpuPackage::aluOp_t aluOp,
	output logic useImmediate,
	output logic registerWrite,
	output CpuPackage::writeSource_t writeSource,
	output CpuPackage::memOp_t memOp,
	output CpuPackage::branchMode_t branchMode
);
	import CpuPackage::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rsField;
	regAddr_t rtField;
	regAddr_t rdField;
	logic signExtend;
	logic readsRs;
	logic readsRt;

	assign opcode = instruction[31:26];
	assign funct = instruction[5:0];
	assign rsField = instruction[25:21];
	assign rtField = instruction[20:16];
	assign rdField = instruction[15:11];

	always_comb begin
		// Defaults describe a no-op
		aluOp = aluPass;
		useImmediate = 1'b0;
		signExtend = 1'b1;
		registerWrite = 1'b0;
		writeSource = writeNone;
		memOp = memNone;
		branchMode = branchNone;
		destAddress = rtField;
		readsRs = 1'b0;
		readsRt = 1'b0;
		case (opcode)
			`OP_RTYPE: begin
				readsRs = 1'b1;
				readsRt = 1'b1;
				registerWrite = 1'b1;
				writeSource = writeAluResult;
				destAddress = rdField;
				case (funct)
					`FN_ADD: aluOp = aluAdd;
					`FN_SUB: aluOp = aluSub;
					`FN_AND: aluOp = aluAnd;
					`FN_OR: aluOp = aluOr;
					`FN_XOR: aluOp = aluXor;
					`FN_NOR: aluOp = aluNor;
					`FN_SLT: aluOp = aluSlt;
					`FN_SLL: aluOp = aluSll;
					`FN_SRL: aluOp = aluSrl;
					`FN_SRA: aluOp = aluSra;
					`FN_JR: begin
						readsRt = 1'b0;
						registerWrite = 1'b0;
						writeSource = writeNone;
						branchMode = branchJumpReg;
					end
					default: begin
						readsRs = 1'b0;
						readsRt = 1'b0;
						registerWrite = 1'b0;
						writeSource = writeNone;
					end
				endcase
			end
			`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI: begin
				readsRs = 1'b1;
				useImmediate = 1'b1;
				registerWrite = 1'b1;
				writeSource = writeAluResult;
				// Logic immediates are zero-extended
				signExtend = opcode == `OP_ADDI || opcode == `OP_SLTI;
				case (opcode)
					`OP_ADDI: aluOp = aluAdd;
					`OP_SLTI: aluOp = aluSlt;
					`OP_ANDI: aluOp = aluAnd;
					`OP_ORI: aluOp = aluOr;
					default: aluOp = aluXor;
				endcase
			end
			`OP_LW: begin
				readsRs = 1'b1;
				useImmediate = 1'b1;
				aluOp = aluAdd;
				registerWrite = 1'b1;
				writeSource = writeMemData;
				memOp = memRead;
			end
			`OP_SW: begin
				readsRs = 1'b1;
				readsRt = 1'b1;
				useImmediate = 1'b1;
				aluOp = aluAdd;
				memOp = memWrite;
			end
			`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
				// Compared as rs minus rt, with rt zero for BLEZ and BGTZ
				readsRs = 1'b1;
				readsRt = 1'b1;
				aluOp = aluSub;
				case (opcode)
					`OP_BEQ: branchMode = branchEq;
					`OP_BNE: branchMode = branchNe;
					`OP_BLEZ: branchMode = branchLez;
					default: branchMode = branchGtz;
				endcase
			end
			`OP_J: branchMode = branchJump;
			`OP_JAL: begin
				branchMode = branchJump;
				registerWrite = 1'b1;
				writeSource = writeLinkAddress;
				destAddress = `LINK_REG;
			end
			default: begin
			end
		endcase
	end

	// Unused source fields read register zero so nothing forwards into them
	assign rsAddress = readsRs ? rsField : '0;
	assign rtAddress = readsRt ? rtField : '0;
	assign immediate = signExtend ? {{16{instruction[15]}}, instruction[15:0]}
		: {16'd0, instruction[15:0]};
	assign jumpTarget = instruction[25:0];
	assign shamt = instruction[10:6];

endmodule

`default_nettype wire

// ==== verilog/Alu.sv ====
`default_nettype none

module Alu (
	input CpuPackage::word_t operandA,
	input CpuPackage::word_t operandB,
	input CpuPackage::shamt_t shamt,
	input CpuPackage::aluOp_t aluOp,
	output CpuPackage::word_t result,
	output logic isZero,
	output logic isPositive,
	output logic isNegative
);
	import CpuPackage::*;

	always_comb begin
		case (aluOp)
			aluAdd: result = operandA + operandB;
			aluSub: result = operandA - operandB;
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			aluXor: result = operandA ^ operandB;
			aluNor: result = ~(operandA | operandB);
			aluSlt: result = {31'd0, $signed(operandA) < $signed(operandB)};
			// Shifts act on the rt operand
			aluSll: result = operandB << shamt;
			aluSrl: result = operandB >> shamt;
			aluSra: result = word_t'($signed(operandB) >>> shamt);
			default: result = operandB;
		endcase
	end

	// Flags of the result, used by branches decoded as sub
	assign isZero = result == '0;
	assign isNegative = result[31];
	assign isPositive = !isZero && !result[31];

endmodule

`default_nettype wire

// ==== common/CpuPackage.sv ====
`default_nettype none

package CpuPackage;

	// Data, address and instruction words
	typedef logic [31:0] word_t;

	// Register index and shift amount fields
	typedef logic [4:0] regAddr_t;
	typedef logic [4:0] shamt_t;

	// Operations the ALU can perform
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSll,
		aluSrl,
		aluSra,
		aluPass
	} aluOp_t;

	// Branch condition evaluated in execute
	typedef enum logic [2:0] {
		branchNone,
		branchEq,
		branchNe,
		branchLez,
		branchGtz,
		branchJump,
		branchJumpReg
	} branchMode_t;

	// Where the writeback value comes from
	typedef enum logic [1:0] {
		writeNone,
		writeAluResult,
		writeMemData,
		writeLinkAddress
	} writeSource_t;

	typedef enum logic [1:0] {
		memNone,
		memRead,
		memWrite
	} memOp_t;

endpackage

`default_nettype wire

// ==== common/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Address map
`define RESET_VECTOR 32'd1024
`define DATA_BASE 32'd1024
`define DISPLAY_ADDRESS 32'd256
`define MEM_WORDS 1024
`define LINK_REG 5'd31

// Opcodes
`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_BLEZ 6'h06
`define OP_BGTZ 6'h07
`define OP_ADDI 6'h08
`define OP_SLTI 6'h0a
`define OP_ANDI 6'h0c
`define OP_ORI 6'h0d
`define OP_XORI 6'h0e
`define OP_LW 6'h23
`define OP_SW 6'h2b

// Funct codes of R-type instructions
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_SRA 6'h03
`define FN_JR 6'h08
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_XOR 6'h26
`define FN_NOR 6'h27
`define FN_SLT 6'h2a

`endif
